// File: Makefile
VERILATOR ?= verilator
TOP ?= cpu_tb
SEED ?= 52
OBJ_DIR ?= obj_dir
FILELIST ?= filelist.f
VFLAGS ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
+incdir+hw
hw/cpu_isa_pkg.sv
hw/cpu_bus_pkg.sv
hw/fetch_if.sv
hw/inst_fetch.sv
hw/gp_registers.sv
hw/execute_unit.sv
hw/bank_write_steer.sv
hw/cpu_top.sv
verification/cpu_model.sv
verification/cpu_tb.sv

// File: hw/bank_write_steer.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module bank_write_steer
(
	input cpu_bus_pkg::mem_write_t wr,
	output logic [`CPU_BANK_ADDR_W-1:0] mem_write_addr_even,
	output logic [`CPU_BANK_ADDR_W-1:0] mem_write_addr_odd,
	output logic [7:0] mem_write_data_even,
	output logic [7:0] mem_write_data_odd,
	output logic mem_write_en_even,
	output logic mem_write_en_odd
);
	logic odd;

	assign odd = wr.addr[0];

	// an odd start puts the high byte in the next even word
	assign mem_write_addr_odd = wr.addr[`CPU_ADDR_W-1:1];
	assign mem_write_addr_even = odd ? wr.addr[`CPU_ADDR_W-1:1] + 1'b1 :
		wr.addr[`CPU_ADDR_W-1:1];

	assign mem_write_data_even = odd ? wr.data[15:8] : wr.data[7:0];
	assign mem_write_data_odd = odd ? wr.data[7:0] : wr.data[15:8];
	assign mem_write_en_even = odd ? wr.be[1] : wr.be[0];
	assign mem_write_en_odd = odd ? wr.be[0] : wr.be[1];

	always_comb
	begin
		assert (wr.be == 2'b11 || !(mem_write_en_even && mem_write_en_odd));
	end

endmodule

// File: hw/cpu_bus_pkg.sv
`include "cpu_macros.svh"

package cpu_bus_pkg;

	typedef enum logic
	{
		REG_X,
		REG_Y
	} reg_sel_t;

	typedef struct packed
	{
		reg_sel_t sel;
		logic [15:0] data;
		logic [1:0] be;
	} reg_write_t;

	// low data byte goes to addr, high byte to addr + 1
	typedef struct packed
	{
		logic [`CPU_ADDR_W-1:0] addr;
		logic [15:0] data;
		logic [1:0] be;
	} mem_write_t;

endpackage

// File: hw/cpu_isa_pkg.sv
`include "cpu_macros.svh"

package cpu_isa_pkg;

	typedef enum logic [7:0]
	{
		OP_NOP = `CPU_OP_NOP,
		OP_TRAP = `CPU_OP_TRAP,
		OP_LD_XL_IMM = `CPU_OP_LD_XL_IMM,
		OP_ADD_IMM = `CPU_OP_ADD_IMM,
		OP_SUB_IMM = `CPU_OP_SUB_IMM,
		OP_AND_IMM = `CPU_OP_AND_IMM,
		OP_OR_IMM = `CPU_OP_OR_IMM,
		OP_XOR_IMM = `CPU_OP_XOR_IMM,
		OP_ADD_YL = `CPU_OP_ADD_YL,
		OP_SUB_YL = `CPU_OP_SUB_YL,
		OP_AND_YL = `CPU_OP_AND_YL,
		OP_OR_YL = `CPU_OP_OR_YL,
		OP_XOR_YL = `CPU_OP_XOR_YL,
		OP_INC_XL = `CPU_OP_INC_XL,
		OP_DEC_XL = `CPU_OP_DEC_XL,
		OP_LD_YL_XL = `CPU_OP_LD_YL_XL,
		OP_LD_DIR_XL = `CPU_OP_LD_DIR_XL,
		OP_LDW_DIR_Y = `CPU_OP_LDW_DIR_Y,
		OP_JR = `CPU_OP_JR,
		OP_JRZ = `CPU_OP_JRZ,
		OP_JRNZ = `CPU_OP_JRNZ,
		OP_JRC = `CPU_OP_JRC,
		OP_JRNC = `CPU_OP_JRNC
	} opcode_t;

	// bit positions in F, upper three bits read zero
	typedef enum logic [2:0]
	{
		FLAG_H,
		FLAG_C,
		FLAG_N,
		FLAG_Z,
		FLAG_O
	} flag_t;

	// opcode sits in the low byte, as it arrives first
	typedef struct packed
	{
		logic [7:0] byte2;
		logic [7:0] byte1;
		opcode_t opcode;
	} inst_t;

	function automatic logic [1:0] inst_len(opcode_t op);
		case (op)
			OP_LD_XL_IMM, OP_ADD_IMM, OP_SUB_IMM, OP_AND_IMM, OP_OR_IMM, OP_XOR_IMM,
			OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC:
				return 2'd2;
			OP_LD_DIR_XL, OP_LDW_DIR_Y:
				return 2'd3;
			default:
				return 2'd1;
		endcase
	endfunction

endpackage

// File: hw/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_ADDR_W 16
`define CPU_BANK_ADDR_W 15
`define CPU_RESET_PC 16'h4000

`define CPU_OP_NOP 8'h00
`define CPU_OP_TRAP 8'h01
`define CPU_OP_LD_XL_IMM 8'h10
`define CPU_OP_ADD_IMM 8'h11
`define CPU_OP_SUB_IMM 8'h12
`define CPU_OP_AND_IMM 8'h13
`define CPU_OP_OR_IMM 8'h14
`define CPU_OP_XOR_IMM 8'h15
`define CPU_OP_ADD_YL 8'h18
`define CPU_OP_SUB_YL 8'h19
`define CPU_OP_AND_YL 8'h1a
`define CPU_OP_OR_YL 8'h1b
`define CPU_OP_XOR_YL 8'h1c
`define CPU_OP_INC_XL 8'h1d
`define CPU_OP_DEC_XL 8'h1e
`define CPU_OP_LD_YL_XL 8'h21
`define CPU_OP_LD_DIR_XL 8'h30
`define CPU_OP_LDW_DIR_Y 8'h31
`define CPU_OP_JR 8'h40
`define CPU_OP_JRZ 8'h41
`define CPU_OP_JRNZ 8'h42
`define CPU_OP_JRC 8'h43
`define CPU_OP_JRNC 8'h44

`endif

// File: hw/cpu_top.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_top
(
	input logic clk,
	input logic reset,
	output logic [`CPU_BANK_ADDR_W-1:0] mem_read_addr_even,
	output logic [`CPU_BANK_ADDR_W-1:0] mem_read_addr_odd,
	input logic [7:0] mem_read_data_even,
	input logic [7:0] mem_read_data_odd,
	output logic [`CPU_BANK_ADDR_W-1:0] mem_write_addr_even,
	output logic [`CPU_BANK_ADDR_W-1:0] mem_write_addr_odd,
	output logic [7:0] mem_write_data_even,
	output logic [7:0] mem_write_data_odd,
	output logic mem_write_en_even,
	output logic mem_write_en_odd,
	output logic trap
);
	import cpu_bus_pkg::*;

	reg_write_t reg_wr;
	mem_write_t mem_wr;
	logic [15:0] x;
	logic [15:0] y;
	logic [7:0] f;
	logic [7:0] f_next;
	logic f_en;

	fetch_if fetch_bus();

	inst_fetch u_inst_fetch
	(
		.clk(clk),
		.reset(reset),
		.mem_read_addr_even(mem_read_addr_even),
		.mem_read_addr_odd(mem_read_addr_odd),
		.mem_read_data_even(mem_read_data_even),
		.mem_read_data_odd(mem_read_data_odd),
		.fetch(fetch_bus.fetch_side)
	);

	gp_registers u_gp_registers
	(
		.clk(clk),
		.reset(reset),
		.wr(reg_wr),
		.f_next(f_next),
		.f_en(f_en),
		.x(x),
		.y(y),
		.f(f)
	);

	execute_unit u_execute_unit
	(
		.fetch(fetch_bus.exec_side),
		.x(x),
		.y(y),
		.f(f),
		.reg_wr(reg_wr),
		.f_next(f_next),
		.f_en(f_en),
		.mem_wr(mem_wr),
		.trap(trap)
	);

	bank_write_steer u_bank_write_steer
	(
		.wr(mem_wr),
		.mem_write_addr_even(mem_write_addr_even),
		.mem_write_addr_odd(mem_write_addr_odd),
		.mem_write_data_even(mem_write_data_even),
		.mem_write_data_odd(mem_write_data_odd),
		.mem_write_en_even(mem_write_en_even),
		.mem_write_en_odd(mem_write_en_odd)
	);

endmodule

// File: hw/execute_unit.sv
`timescale 1ns/10ps

module execute_unit
(
	fetch_if.exec_side fetch,
	input logic [15:0] x,
	input logic [15:0] y,
	input logic [7:0] f,
	output cpu_bus_pkg::reg_write_t reg_wr,
	output logic [7:0] f_next,
	output logic f_en,
	output cpu_bus_pkg::mem_write_t mem_wr,
	output logic trap
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	opcode_t op;
	logic [7:0] imm;
	logic [7:0] operand;
	logic [7:0] addend;
	logic carry_in;
	logic [8:0] sum;
	logic [4:0] half_sum;
	logic [7:0] logic_res;
	logic [7:0] arith_f;
	logic [7:0] logic_f;
	logic take;

	assign op = fetch.inst.opcode;
	assign imm = fetch.inst.byte1;
	assign operand = (op inside {OP_ADD_YL, OP_SUB_YL, OP_AND_YL, OP_OR_YL, OP_XOR_YL}) ?
		y[7:0] : imm;

	// subtraction as complement plus one, so C is no borrow
	always_comb
	begin
		case (op)
			OP_SUB_IMM, OP_SUB_YL:
			begin
				addend = ~operand;
				carry_in = 1'b1;
			end
			OP_INC_XL:
			begin
				addend = 8'h01;
				carry_in = 1'b0;
			end
			OP_DEC_XL:
			begin
				addend = 8'hfe;
				carry_in = 1'b1;
			end
			default:
			begin
				addend = operand;
				carry_in = 1'b0;
			end
		endcase
	end

	assign sum = {1'b0, x[7:0]} + {1'b0, addend} + {8'h00, carry_in};
	assign half_sum = {1'b0, x[3:0]} + {1'b0, addend[3:0]} + {4'h0, carry_in};

	always_comb
	begin
		arith_f = 8'h00;
		arith_f[FLAG_H] = half_sum[4];
		arith_f[FLAG_C] = sum[8];
		arith_f[FLAG_N] = sum[7];
		arith_f[FLAG_Z] = (sum[7:0] == 8'h00);
		arith_f[FLAG_O] = (x[7] == addend[7]) && (sum[7] != x[7]);
	end

	always_comb
	begin
		case (op)
			OP_AND_IMM, OP_AND_YL:
				logic_res = x[7:0] & operand;
			OP_OR_IMM, OP_OR_YL:
				logic_res = x[7:0] | operand;
			default:
				logic_res = x[7:0] ^ operand;
		endcase
		// H, C and O kept
		logic_f = f;
		logic_f[FLAG_Z] = (logic_res == 8'h00);
		logic_f[FLAG_N] = logic_res[7];
	end

	always_comb
	begin
		case (op)
			OP_JR:
				take = 1'b1;
			OP_JRZ:
				take = f[FLAG_Z];
			OP_JRNZ:
				take = !f[FLAG_Z];
			OP_JRC:
				take = f[FLAG_C];
			OP_JRNC:
				take = !f[FLAG_C];
			default:
				take = 1'b0;
		endcase
	end

	assign fetch.redirect = fetch.execute && take;
	assign fetch.target = fetch.pc + {{8{imm[7]}}, imm};
	assign fetch.halt = fetch.execute && (op == OP_TRAP);
	assign trap = fetch.halt;

	always_comb
	begin
		reg_wr.sel = REG_X;
		reg_wr.data = {8'h00, sum[7:0]};
		reg_wr.be = 2'b00;
		f_next = f;
		f_en = 1'b0;
		// direct address, low byte first
		mem_wr.addr = {fetch.inst.byte2, fetch.inst.byte1};
		mem_wr.data = y;
		mem_wr.be = 2'b00;
		if (fetch.execute)
		begin
			case (op)
				OP_LD_XL_IMM:
				begin
					reg_wr.data = {8'h00, imm};
					reg_wr.be = 2'b01;
				end
				OP_ADD_IMM, OP_SUB_IMM, OP_ADD_YL, OP_SUB_YL, OP_INC_XL, OP_DEC_XL:
				begin
					reg_wr.be = 2'b01;
					f_next = arith_f;
					f_en = 1'b1;
				end
				OP_AND_IMM, OP_OR_IMM, OP_XOR_IMM, OP_AND_YL, OP_OR_YL, OP_XOR_YL:
				begin
					reg_wr.data = {8'h00, logic_res};
					reg_wr.be = 2'b01;
					f_next = logic_f;
					f_en = 1'b1;
				end
				OP_LD_YL_XL:
				begin
					reg_wr.sel = REG_Y;
					reg_wr.data = {8'h00, x[7:0]};
					reg_wr.be = 2'b01;
				end
				OP_LD_DIR_XL:
				begin
					mem_wr.data = {8'h00, x[7:0]};
					mem_wr.be = 2'b01;
				end
				OP_LDW_DIR_Y:
					mem_wr.be = 2'b11;
				default:
				begin
				end
			endcase
		end
	end

	always_comb
	begin
		assert (fetch.execute || (reg_wr.be == 2'b00 && mem_wr.be == 2'b00));
	end

endmodule

// File: hw/fetch_if.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

interface fetch_if;
	cpu_isa_pkg::inst_t inst;
	logic [`CPU_ADDR_W-1:0] pc;
	logic execute;

	// only meaningful while execute is high
	logic redirect;
	logic [`CPU_ADDR_W-1:0] target;
	logic halt;

	modport fetch_side
	(
		output inst, pc, execute,
		input redirect, target, halt
	);

	modport exec_side
	(
		input inst, pc, execute,
		output redirect, target, halt
	);
endinterface

// File: hw/gp_registers.sv
`timescale 1ns/10ps

module gp_registers
(
	input logic clk,
	input logic reset,
	input cpu_bus_pkg::reg_write_t wr,
	input logic [7:0] f_next,
	input logic f_en,
	output logic [15:0] x,
	output logic [15:0] y,
	output logic [7:0] f
);
	import cpu_bus_pkg::*;

	always_ff @(posedge clk)
	begin
		for (int b = 0; b < 2; b++)
		begin
			if (wr.be[b] && wr.sel == REG_X)
				x[b*8 +: 8] <= wr.data[b*8 +: 8];
			if (wr.be[b] && wr.sel == REG_Y)
				y[b*8 +: 8] <= wr.data[b*8 +: 8];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			f <= 8'h00;
		else if (f_en)
			f <= f_next;
	end

endmodule

// File: hw/inst_fetch.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module inst_fetch
(
	input logic clk,
	input logic reset,
	output logic [`CPU_BANK_ADDR_W-1:0] mem_read_addr_even,
	output logic [`CPU_BANK_ADDR_W-1:0] mem_read_addr_odd,
	input logic [7:0] mem_read_data_even,
	input logic [7:0] mem_read_data_odd,
	fetch_if.fetch_side fetch
);
	import cpu_isa_pkg::*;

	logic [`CPU_ADDR_W-1:0] pc;
	logic held;
	logic [15:0] hold_lo;
	logic [`CPU_ADDR_W-1:0] rd_addr;
	logic [7:0] lo;
	logic [7:0] hi;
	logic [7:0] opcode_now;
	logic [1:0] len;

	// upper byte cycle reads past the two held bytes
	assign rd_addr = held ? pc + 16'd2 : pc;

	assign mem_read_addr_odd = rd_addr[`CPU_ADDR_W-1:1];
	assign mem_read_addr_even = rd_addr[0] ? rd_addr[`CPU_ADDR_W-1:1] + 1'b1 :
		rd_addr[`CPU_ADDR_W-1:1];

	assign lo = rd_addr[0] ? mem_read_data_odd : mem_read_data_even;
	assign hi = rd_addr[0] ? mem_read_data_even : mem_read_data_odd;

	assign opcode_now = held ? hold_lo[7:0] : lo;
	assign len = inst_len(opcode_t'(opcode_now));

	assign fetch.inst = held ? inst_t'({lo, hold_lo}) : inst_t'({8'h00, hi, lo});
	assign fetch.pc = pc;
	assign fetch.execute = !reset && (held || len != 2'd3);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= `CPU_RESET_PC;
			held <= 1'b0;
		end
		else if (fetch.execute)
		begin
			held <= 1'b0;
			if (!fetch.halt)
				pc <= fetch.redirect ? fetch.target : pc + {14'h0000, len};
		end
		else
			held <= 1'b1;
	end

	// opcode and byte1 of a long instruction
	always_ff @(posedge clk)
	begin
		if (!held)
			hold_lo <= {hi, lo};
	end

	held_only_long: assert property (@(posedge clk) disable iff (reset)
		held |-> inst_len(opcode_t'(hold_lo[7:0])) == 2'd3);

endmodule

// File: verification/cpu_model.sv
`include "cpu_macros.svh"

package cpu_model;

	// positions in F
	localparam int H_BIT = 0;
	localparam int C_BIT = 1;
	localparam int N_BIT = 2;
	localparam int Z_BIT = 3;
	localparam int O_BIT = 4;
	localparam int MAX_STEPS = 256;

	// program image starting at 4000, and the stores it should make
	logic [7:0] code[$];
	logic [15:0] exp_addr[$];
	logic [7:0] exp_data[$];
	bit exp_known[$];

	logic [7:0] xl;
	logic [7:0] yl;
	logic [7:0] fl;

	function automatic void emit(logic [7:0] b);
		code.push_back(b);
	endfunction

	function automatic void emit_with_addr(logic [7:0] op, logic [15:0] a);
		emit(op);
		emit(a[7:0]);
		emit(a[15:8]);
	endfunction

	// store targets stay well below the program
	function automatic logic [15:0] data_addr();
		return 16'(($urandom % 32'h1ffe) + 32'h0100);
	endfunction

	function automatic void emit_alu_op();
		logic [7:0] ops[14];
		int k;
		ops = '{`CPU_OP_LD_XL_IMM, `CPU_OP_ADD_IMM, `CPU_OP_SUB_IMM, `CPU_OP_AND_IMM,
			`CPU_OP_OR_IMM, `CPU_OP_XOR_IMM, `CPU_OP_ADD_YL, `CPU_OP_SUB_YL,
			`CPU_OP_AND_YL, `CPU_OP_OR_YL, `CPU_OP_XOR_YL, `CPU_OP_INC_XL,
			`CPU_OP_DEC_XL, `CPU_OP_LD_YL_XL};
		k = int'($urandom_range(13, 0));
		emit(ops[k]);
		// first six carry an immediate
		if (k < 6)
			emit(8'($urandom));
	endfunction

	// defines XL and YL before anything reads them
	function automatic void emit_preamble();
		int n;
		int i;
		code.delete();
		emit(`CPU_OP_LD_XL_IMM);
		emit(8'($urandom));
		emit(`CPU_OP_LD_YL_XL);
		emit(`CPU_OP_LD_XL_IMM);
		emit(8'($urandom));
		n = int'($urandom_range(10, 4));
		for (i = 0; i < n; i++)
			emit_alu_op();
	endfunction

	function automatic void gen_alu_program();
		emit_preamble();
		emit_with_addr(`CPU_OP_LD_DIR_XL, data_addr());
		emit(`CPU_OP_TRAP);
	endfunction

	function automatic void gen_word_program(bit odd);
		logic [15:0] a;
		emit_preamble();
		emit(`CPU_OP_LD_YL_XL);
		a = data_addr();
		a[0] = odd;
		emit_with_addr(`CPU_OP_LDW_DIR_Y, a);
		emit(`CPU_OP_TRAP);
	endfunction

	function automatic void gen_jump_program();
		logic [7:0] jops[5];
		logic [7:0] v;
		jops = '{`CPU_OP_JR, `CPU_OP_JRZ, `CPU_OP_JRNZ, `CPU_OP_JRC, `CPU_OP_JRNC};
		emit_preamble();
		v = 8'($urandom);
		emit(`CPU_OP_LD_XL_IMM);
		emit(v);
		// equal operands half the time, so Z gets set
		emit(`CPU_OP_SUB_IMM);
		emit(($urandom_range(1, 0) == 1) ? v : 8'($urandom));
		emit(jops[$urandom_range(4, 0)]);
		// lands just past the first store
		emit(8'd5);
		emit_with_addr(`CPU_OP_LD_DIR_XL, data_addr());
		emit_with_addr(`CPU_OP_LD_DIR_XL, data_addr());
		emit(`CPU_OP_TRAP);
	endfunction

	function automatic logic [7:0] code_at(logic [15:0] a);
		int i;
		i = int'(a) - 32'h4000;
		if (i >= 0 && i < code.size())
			return code[i];
		return 8'h00;
	endfunction

	function automatic int op_len(logic [7:0] op);
		case (op)
			`CPU_OP_LD_XL_IMM, `CPU_OP_ADD_IMM, `CPU_OP_SUB_IMM, `CPU_OP_AND_IMM,
			`CPU_OP_OR_IMM, `CPU_OP_XOR_IMM, `CPU_OP_JR, `CPU_OP_JRZ, `CPU_OP_JRNZ,
			`CPU_OP_JRC, `CPU_OP_JRNC:
				return 2;
			`CPU_OP_LD_DIR_XL, `CPU_OP_LDW_DIR_Y:
				return 3;
			default:
				return 1;
		endcase
	endfunction

	// flags from plain integer arithmetic; C on sub means no borrow
	function automatic void arith(logic [7:0] b, bit sub);
		int ur;
		int sr;
		ur = sub ? int'(xl) - int'(b) : int'(xl) + int'(b);
		sr = sub ? int'($signed(xl)) - int'($signed(b)) : int'($signed(xl)) + int'($signed(b));
		fl = 8'h00;
		fl[H_BIT] = sub ? (xl[3:0] >= b[3:0]) : (int'(xl[3:0]) + int'(b[3:0]) > 15);
		fl[C_BIT] = sub ? (xl >= b) : (ur > 255);
		fl[O_BIT] = (sr > 127) || (sr < -128);
		xl = 8'(ur);
		fl[N_BIT] = xl[7];
		fl[Z_BIT] = (xl == 8'h00);
	endfunction

	function automatic void logic_result(logic [7:0] r);
		xl = r;
		fl[N_BIT] = r[7];
		fl[Z_BIT] = (r == 8'h00);
	endfunction

	function automatic bit jump_taken(logic [7:0] op);
		case (op)
			`CPU_OP_JRZ:
				return fl[Z_BIT];
			`CPU_OP_JRNZ:
				return !fl[Z_BIT];
			`CPU_OP_JRC:
				return fl[C_BIT];
			`CPU_OP_JRNC:
				return !fl[C_BIT];
			default:
				return 1'b1;
		endcase
	endfunction

	function automatic void expect_write(logic [15:0] a, logic [7:0] d, bit known);
		exp_addr.push_back(a);
		exp_data.push_back(d);
		exp_known.push_back(known);
	endfunction

	// runs from 4000 up to TRAP; YH is never written, so its byte is unknown
	function automatic void interpret_program();
		logic [15:0] pc;
		logic [15:0] next_pc;
		logic [15:0] a;
		logic [7:0] op;
		logic [7:0] b1;
		int steps;
		bit done;
		exp_addr.delete();
		exp_data.delete();
		exp_known.delete();
		pc = 16'h4000;
		fl = 8'h00;
		done = 1'b0;
		for (steps = 0; steps < MAX_STEPS && !done; steps++)
		begin
			op = code_at(pc);
			b1 = code_at(pc + 16'd1);
			a = {code_at(pc + 16'd2), b1};
			next_pc = pc + 16'(op_len(op));
			case (op)
				`CPU_OP_TRAP:
					done = 1'b1;
				`CPU_OP_LD_XL_IMM:
					xl = b1;
				`CPU_OP_ADD_IMM:
					arith(b1, 1'b0);
				`CPU_OP_SUB_IMM:
					arith(b1, 1'b1);
				`CPU_OP_ADD_YL:
					arith(yl, 1'b0);
				`CPU_OP_SUB_YL:
					arith(yl, 1'b1);
				`CPU_OP_INC_XL:
					arith(8'h01, 1'b0);
				`CPU_OP_DEC_XL:
					arith(8'h01, 1'b1);
				`CPU_OP_AND_IMM:
					logic_result(xl & b1);
				`CPU_OP_OR_IMM:
					logic_result(xl | b1);
				`CPU_OP_XOR_IMM:
					logic_result(xl ^ b1);
				`CPU_OP_AND_YL:
					logic_result(xl & yl);
				`CPU_OP_OR_YL:
					logic_result(xl | yl);
				`CPU_OP_XOR_YL:
					logic_result(xl ^ yl);
				`CPU_OP_LD_YL_XL:
					yl = xl;
				`CPU_OP_LD_DIR_XL:
					expect_write(a, xl, 1'b1);
				`CPU_OP_LDW_DIR_Y:
				begin
					expect_write(a, yl, 1'b1);
					expect_write(a + 16'd1, 8'h00, 1'b0);
				end
				`CPU_OP_JR, `CPU_OP_JRZ, `CPU_OP_JRNZ, `CPU_OP_JRC, `CPU_OP_JRNC:
				begin
					if (jump_taken(op))
						next_pc = pc + {{8{b1[7]}}, b1};
				end
				default:
				begin
				end
			endcase
			pc = next_pc;
		end
	endfunction

endpackage

// File: verification/cpu_tb.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_tb;
	import cpu_model::*;

	localparam int NUM_TESTS = 15;
	localparam int RESET_CYCLES = 16;
	localparam int TAIL_CYCLES = 20;

	logic clk;
	logic reset;
	logic [14:0] mem_read_addr_even;
	logic [14:0] mem_read_addr_odd;
	logic [7:0] mem_read_data_even;
	logic [7:0] mem_read_data_odd;
	logic [14:0] mem_write_addr_even;
	logic [14:0] mem_write_addr_odd;
	logic [7:0] mem_write_data_even;
	logic [7:0] mem_write_data_odd;
	logic mem_write_en_even;
	logic mem_write_en_odd;
	logic trap;

	logic [7:0] bank_even[32768];
	logic [7:0] bank_odd[32768];
	logic [15:0] even_byte_addr;
	logic [15:0] odd_byte_addr;

	// observed byte writes
	logic [15:0] got_addr[$];
	logic [7:0] got_data[$];
	bit trap_seen;
	int writes_at_trap;

	logic [7:0] all_code[$];
	int prog_start[NUM_TESTS];
	int prog_len[NUM_TESTS];

	int cycles;
	int cycle_limit;
	int errors;
	int passed;
	int failed;

	cpu_top dut
	(
		.clk(clk),
		.reset(reset),
		.mem_read_addr_even(mem_read_addr_even),
		.mem_read_addr_odd(mem_read_addr_odd),
		.mem_read_data_even(mem_read_data_even),
		.mem_read_data_odd(mem_read_data_odd),
		.mem_write_addr_even(mem_write_addr_even),
		.mem_write_addr_odd(mem_write_addr_odd),
		.mem_write_data_even(mem_write_data_even),
		.mem_write_data_odd(mem_write_data_odd),
		.mem_write_en_even(mem_write_en_even),
		.mem_write_en_odd(mem_write_en_odd),
		.trap(trap)
	);

	always #2 clk = ~clk;

	assign mem_read_data_even = bank_even[mem_read_addr_even];
	assign mem_read_data_odd = bank_odd[mem_read_addr_odd];
	assign even_byte_addr = {mem_write_addr_even, 1'b0};
	assign odd_byte_addr = {mem_write_addr_odd, 1'b1};

	always @(posedge clk)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// mid-cycle sampling, inputs move just after the rising edge
	always @(negedge clk)
	begin
		if (reset)
		begin
			assert (!mem_write_en_even && !mem_write_en_odd && !trap)
			else
			begin
				$display("write enable or trap is high while reset is asserted");
				errors++;
			end
		end
		else
		begin
			// lower byte address first
			if (mem_write_en_odd && (!mem_write_en_even || odd_byte_addr < even_byte_addr))
			begin
				got_addr.push_back(odd_byte_addr);
				got_data.push_back(mem_write_data_odd);
				if (mem_write_en_even)
				begin
					got_addr.push_back(even_byte_addr);
					got_data.push_back(mem_write_data_even);
				end
			end
			else
			begin
				if (mem_write_en_even)
				begin
					got_addr.push_back(even_byte_addr);
					got_data.push_back(mem_write_data_even);
				end
				if (mem_write_en_odd)
				begin
					got_addr.push_back(odd_byte_addr);
					got_data.push_back(mem_write_data_odd);
				end
			end
			if (trap && !trap_seen)
			begin
				trap_seen = 1'b1;
				writes_at_trap = got_addr.size();
			end
		end
	end

	function automatic logic [7:0] fill_byte(logic [15:0] a);
		return a[7:0] ^ a[15:8] ^ 8'h5a;
	endfunction

	function automatic string test_name(int t);
		case (t % 3)
			0:
				return $sformatf("alu_%0d", t);
			1:
				return $sformatf("store_word_%0d", t);
			default:
				return $sformatf("jump_%0d", t);
		endcase
	endfunction

	task automatic load_memory();
		int i;
		logic [15:0] a;
		for (i = 0; i < 32768; i++)
		begin
			a = 16'(2 * i);
			bank_even[i] = fill_byte(a);
			bank_odd[i] = fill_byte(a | 16'd1);
		end
		for (i = 0; i < code.size(); i++)
		begin
			a = 16'h4000 + 16'(i);
			if (a[0])
				bank_odd[a[15:1]] = code[i];
			else
				bank_even[a[15:1]] = code[i];
		end
	endtask

	task automatic check_writes(string name);
		int i;
		assert (got_addr.size() == exp_addr.size())
		else
		begin
			$display("Mismatch %s write count: expected %0d, actual %0d",
				name, exp_addr.size(), got_addr.size());
			errors++;
		end
		for (i = 0; i < exp_addr.size() && i < got_addr.size(); i++)
		begin
			assert (got_addr[i] == exp_addr[i])
			else
			begin
				$display("Mismatch %s write %0d address: expected %h, actual %h",
					name, i, exp_addr[i], got_addr[i]);
				errors++;
			end
			assert (!exp_known[i] || got_data[i] == exp_data[i])
			else
			begin
				$display("Mismatch %s write %0d data: expected %h, actual %h",
					name, i, exp_data[i], got_data[i]);
				errors++;
			end
		end
	endtask

	task automatic run_test(int t);
		string name;
		int err_before;
		int i;
		name = test_name(t);
		err_before = errors;
		code.delete();
		for (i = 0; i < prog_len[t]; i++)
			code.push_back(all_code[prog_start[t] + i]);
		interpret_program();
		load_memory();
		got_addr.delete();
		got_data.delete();
		trap_seen = 1'b0;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		assert (mem_read_addr_even == 15'h2000 && mem_read_addr_odd == 15'h2000)
		else
		begin
			$display("Mismatch %s first read address: expected 2000/2000, actual %h/%h",
				name, mem_read_addr_even, mem_read_addr_odd);
			errors++;
		end
		while (!trap_seen)
			@(negedge clk);
		assert (writes_at_trap == exp_addr.size())
		else
		begin
			$display("Mismatch %s writes before trap: expected %0d, actual %0d",
				name, exp_addr.size(), writes_at_trap);
			errors++;
		end
		for (i = 0; i < TAIL_CYCLES; i++)
		begin
			@(negedge clk);
			assert (trap)
			else
			begin
				$display("%s: trap dropped %0d cycles after it was raised", name, i + 1);
				errors++;
			end
		end
		check_writes(name);
		@(posedge clk);
		#1;
		if (errors == err_before)
		begin
			passed++;
			$display("test %s passed", name);
		end
		else
		begin
			failed++;
			$display("test %s failed", name);
		end
	endtask

	initial
	begin
		int t;
		int i;
		int total;
		clk = 1'b0;
		reset = 1'b1;
		cycles = 0;
		cycle_limit = 0;
		errors = 0;
		passed = 0;
		failed = 0;
		trap_seen = 1'b0;
		writes_at_trap = 0;
		code.delete();
		load_memory();
		void'($urandom(52));
		total = 0;
		for (t = 0; t < NUM_TESTS; t++)
		begin
			case (t % 3)
				0:
					gen_alu_program();
				1:
					gen_word_program(((t / 3) % 2) == 1);
				default:
					gen_jump_program();
			endcase
			prog_start[t] = all_code.size();
			prog_len[t] = code.size();
			for (i = 0; i < code.size(); i++)
				all_code.push_back(code[i]);
			total += code.size();
		end
		cycle_limit = 40 * total;
		@(posedge clk);
		#1;
		for (t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("tests passed %0d, failed %0d, check errors %0d", passed, failed, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
